// ==== sim.f ====
+incdir+include
rtl/riscv_isa_pkg.sv
rtl/riscv_estage_pkg.sv
rtl/riscv_alu.sv
rtl/riscv_muldiv.sv
rtl/riscv_icu.sv
rtl/riscv_lsu.sv
rtl/riscv_misalignment_unit.sv
rtl/riscv_estage.sv
verification/tb_riscv_estage.sv

// ==== Bender.yml ====
package:
  name: riscv_estage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/riscv_isa_pkg.sv
      - rtl/riscv_estage_pkg.sv
      - rtl/riscv_alu.sv
      - rtl/riscv_muldiv.sv
      - rtl/riscv_icu.sv
      - rtl/riscv_lsu.sv
      - rtl/riscv_misalignment_unit.sv
      - rtl/riscv_estage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/tb_riscv_estage.sv

// ==== verification/tb_riscv_estage.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module tb_riscv_estage;

  localparam int TIMEOUT_CYCLES = 200;
  localparam logic [`RISCV_XLEN-1:0] MIN_NEG  = {1'b1, {(`RISCV_XLEN-1){1'b0}}};
  localparam logic [`RISCV_XLEN-1:0] ALL_ONES = '1;

  logic                           clk;
  logic                           rst;
  riscv_estage_pkg::estage_ctrl_t ctrl;
  logic [`RISCV_XLEN-1:0]         rs1;
  logic [`RISCV_XLEN-1:0]         rs2;
  riscv_estage_pkg::fwd_data_t    fwd;
  logic [`RISCV_XLEN-1:0]         pc;
  logic [`RISCV_XLEN-1:0]         simm;
  logic [`RISCV_XLEN-1:0]         immext;
  logic                           gtrap;
  logic                           rtrap;
  logic [`RISCV_XLEN-1:0]         result;
  logic [`RISCV_XLEN-1:0]         store_data;
  logic [`RISCV_XLEN-1:0]         csr_data;
  logic                           branch_taken;
  logic                           mul_en;
  logic                           div_en;
  logic                           icu_valid;
  riscv_estage_pkg::mem_req_t     mem_req;
  logic [`RISCV_XLEN-1:0]         rddata_sc;
  riscv_estage_pkg::trap_flags_t  traps;

  int          errors;
  int          checks;
  logic [63:0] lcg_state;

  riscv_estage dut (
    .i_riscv_estage_clk (clk),
    .i_rst              (rst),
    .i_ctrl             (ctrl),
    .i_rs1data          (rs1),
    .i_rs2data          (rs2),
    .i_fwd              (fwd),
    .i_pc               (pc),
    .i_simm             (simm),
    .i_immextended      (immext),
    .i_gtrap            (gtrap),
    .i_rtrap            (rtrap),
    .o_result           (result),
    .o_store_data       (store_data),
    .o_csrwritedata     (csr_data),
    .o_branchtaken      (branch_taken),
    .o_mul_en           (mul_en),
    .o_div_en           (div_en),
    .o_icu_valid        (icu_valid),
    .o_mem_req          (mem_req),
    .o_rddata_sc        (rddata_sc),
    .o_traps            (traps)
  );

  always #4 clk = ~clk;   // 8 ns period

  // Two LCG steps, upper halves joined
  function automatic logic [63:0] next_rand();
    logic [31:0] upper;
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    upper = lcg_state[63:32];
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return {upper, lcg_state[63:32]};
  endfunction

  function automatic logic [63:0] alu_model(input riscv_isa_pkg::alu_op_e op,
                                            input logic [63:0] a, input logic [63:0] b);
    logic       lt;
    logic [5:0] s;
    s  = b[5:0];
    lt = (a[63] != b[63]) ? a[63] : (a < b);   // Signed compare from sign bits
    case (op)
      riscv_isa_pkg::ALU_ADD:    return a + b;
      riscv_isa_pkg::ALU_SUB:    return a - b;
      riscv_isa_pkg::ALU_SLL:    return a << s;
      riscv_isa_pkg::ALU_SLT:    return {63'd0, lt};
      riscv_isa_pkg::ALU_SLTU:   return {63'd0, a < b};
      riscv_isa_pkg::ALU_XOR:    return a ^ b;
      riscv_isa_pkg::ALU_SRL:    return a >> s;
      riscv_isa_pkg::ALU_SRA:    return (a >> s) | (a[63] ? ~(ALL_ONES >> s) : 64'd0);
      riscv_isa_pkg::ALU_OR:     return a | b;
      riscv_isa_pkg::ALU_AND:    return a & b;
      riscv_isa_pkg::ALU_PASS_B: return b;
      default:                   return 64'd0;
    endcase
  endfunction

  function automatic logic branch_model(input riscv_isa_pkg::bcond_e bc,
                                        input logic [63:0] x, input logic [63:0] y);
    logic lt;
    lt = (x[63] != y[63]) ? x[63] : (x < y);
    case (bc)
      riscv_isa_pkg::BC_BEQ:  return x == y;
      riscv_isa_pkg::BC_BNE:  return x != y;
      riscv_isa_pkg::BC_BLT:  return lt;
      riscv_isa_pkg::BC_BGE:  return !lt;
      riscv_isa_pkg::BC_BLTU: return x < y;
      riscv_isa_pkg::BC_BGEU: return x >= y;
      riscv_isa_pkg::BC_JUMP: return 1'b1;
      default:                return 1'b0;
    endcase
  endfunction

  function automatic logic [63:0] md_model(input riscv_isa_pkg::muldiv_op_e op,
                                           input logic [63:0] a, input logic [63:0] b);
    logic [127:0] ea;
    logic [127:0] eb;
    logic [127:0] p;
    logic         ovf;
    ea  = (op inside {riscv_isa_pkg::MD_MULH, riscv_isa_pkg::MD_MULHSU}) ?
          {{64{a[63]}}, a} : {64'd0, a};
    eb  = (op == riscv_isa_pkg::MD_MULH) ? {{64{b[63]}}, b} : {64'd0, b};
    p   = ea * eb;   // Modulo 2^128 product of the extended operands
    ovf = (a == MIN_NEG) && (b == ALL_ONES);
    case (op)
      riscv_isa_pkg::MD_MUL: return p[63:0];
      riscv_isa_pkg::MD_DIV: begin
        if (b == 64'd0) return ALL_ONES;
        if (ovf) return a;
        return $signed(a) / $signed(b);
      end
      riscv_isa_pkg::MD_DIVU: return (b == 64'd0) ? ALL_ONES : a / b;
      riscv_isa_pkg::MD_REM: begin
        if (b == 64'd0) return a;
        if (ovf) return 64'd0;
        return $signed(a) % $signed(b);
      end
      riscv_isa_pkg::MD_REMU: return (b == 64'd0) ? a : a % b;
      default: return p[127:64];
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic drive_idle();
    ctrl           = '0;
    ctrl.oprnd1sel = 1'b1;
    ctrl.alu_op    = riscv_isa_pkg::ALU_ADD;
    ctrl.bcond     = riscv_isa_pkg::BC_NONE;
    ctrl.muldiv_op = riscv_isa_pkg::MD_NONE;
    ctrl.funcsel   = riscv_isa_pkg::FS_ALU;
    ctrl.opcode    = riscv_isa_pkg::OPC_OP;
    ctrl.memsize   = riscv_isa_pkg::MS_D;
    gtrap          = 1'b0;
    rtrap          = 1'b0;
  endtask

  task automatic test_alu_paths();
    riscv_isa_pkg::alu_op_e op;
    logic [63:0]            a;
    logic [63:0]            b;
    for (int k = 0; k <= 10; k++) begin
      op = riscv_isa_pkg::alu_op_e'(k);
      for (int sel = 0; sel < 4; sel++) begin
        for (int n = 0; n < 3; n++) begin
          @(negedge clk);
          drive_idle();
          ctrl.alu_op    = op;
          ctrl.oprnd1sel = sel[0];
          ctrl.oprnd2sel = sel[1];
          rs1  = next_rand();
          rs2  = next_rand();
          pc   = next_rand();
          simm = next_rand();
          a = sel[0] ? rs1 : pc;   // Operand A from pc unless rs1 is selected
          b = sel[1] ? simm : rs2;
          #2;
          check_value($sformatf("alu %s sel %0d", op.name(), sel), alu_model(op, a, b), result);
          check_bit($sformatf("alu %s valid", op.name()), 1'b1, icu_valid);
        end
      end
    end
  endtask

  task automatic test_forwarding();
    logic [63:0] src_a [4];
    logic [63:0] src_b [4];
    for (int fa = 0; fa < 4; fa++) begin
      for (int fb = 0; fb < 4; fb++) begin
        for (int ir = 0; ir < 2; ir++) begin
          @(negedge clk);
          drive_idle();
          rs1          = next_rand();
          rs2          = next_rand();
          fwd.rdata_wb = next_rand();
          fwd.rddata_m = next_rand();
          fwd.imm_m    = next_rand();
          immext       = next_rand();
          ctrl.fwda    = fa[1:0];
          ctrl.fwdb    = fb[1:0];
          ctrl.imm_reg = ir[0];
          src_a = '{rs1, fwd.rdata_wb, fwd.rddata_m, fwd.imm_m};
          src_b = '{rs2, fwd.rdata_wb, fwd.rddata_m, fwd.imm_m};
          #2;
          check_value($sformatf("fwd add a%0d b%0d", fa, fb), src_a[fa] + src_b[fb], result);
          check_value($sformatf("fwd store b%0d", fb), src_b[fb], store_data);
          check_value($sformatf("csr data a%0d imm %0d", fa, ir),
                      ir ? immext : src_a[fa], csr_data);
        end
      end
    end
  endtask

  task automatic test_branches();
    riscv_isa_pkg::bcond_e conds [8];
    logic [63:0]           xs [8];
    logic [63:0]           ys [8];
    conds = '{riscv_isa_pkg::BC_NONE, riscv_isa_pkg::BC_BEQ, riscv_isa_pkg::BC_BNE,
              riscv_isa_pkg::BC_JUMP, riscv_isa_pkg::BC_BLT, riscv_isa_pkg::BC_BGE,
              riscv_isa_pkg::BC_BLTU, riscv_isa_pkg::BC_BGEU};
    xs = '{64'd5, MIN_NEG, ~MIN_NEG, ALL_ONES, 64'd0, 64'd7, next_rand(), next_rand()};
    ys = '{64'd5, ~MIN_NEG, MIN_NEG, 64'd0, ALL_ONES, 64'd9, next_rand(), next_rand()};
    foreach (conds[c]) begin
      foreach (xs[n]) begin
        @(negedge clk);
        drive_idle();
        ctrl.bcond = conds[c];
        rs1 = xs[n];
        rs2 = ys[n];
        #2;
        check_bit($sformatf("branch %s pair %0d", conds[c].name(), n),
                  branch_model(conds[c], xs[n], ys[n]), branch_taken);
      end
    end
  endtask

  task automatic test_muldiv();
    riscv_isa_pkg::muldiv_op_e op;
    logic [63:0]               xs [6];
    logic [63:0]               ys [6];
    int                        waited;
    logic                      seen;
    for (int k = 8; k < 16; k++) begin
      op = riscv_isa_pkg::muldiv_op_e'(k);
      xs = '{next_rand(), next_rand(), next_rand(), MIN_NEG, ALL_ONES, MIN_NEG};
      ys = '{next_rand(), next_rand(), 64'd0, ALL_ONES, ALL_ONES, 64'd1};
      foreach (xs[n]) begin
        @(negedge clk);
        drive_idle();
        ctrl.muldiv_op = op;
        ctrl.funcsel   = riscv_isa_pkg::FS_MULDIV;
        rs1    = xs[n];
        rs2    = ys[n];
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < TIMEOUT_CYCLES) begin
          @(negedge clk);
          waited++;
          check_bit($sformatf("%s mul_en", op.name()), k < 12, mul_en);
          check_bit($sformatf("%s div_en", op.name()), k >= 12, div_en);
          seen = icu_valid;
        end
        if (!seen) begin
          errors++;
          $display("Timeout: %s gave no valid within %0d cycles", op.name(), TIMEOUT_CYCLES);
        end else begin
          check_value($sformatf("%s result pair %0d", op.name(), n), md_model(op, xs[n], ys[n]),
                      result);
          check_value($sformatf("%s latency", op.name()), 64'd65, 64'(waited));
        end
        drive_idle();   // Release so the unit goes back to idle
      end
    end
  endtask

  task automatic drive_atomic(input logic is_sc, input logic [63:0] addr);
    @(negedge clk);
    drive_idle();
    ctrl.lr   = !is_sc;
    ctrl.memr = !is_sc;
    ctrl.sc   = is_sc;
    ctrl.memw = is_sc;
    rs1       = addr;
    simm      = next_rand();
    #2;
  endtask

  task automatic test_memory();
    logic [63:0] x;
    for (int st = 0; st < 2; st++) begin
      @(negedge clk);
      drive_idle();
      ctrl.opcode    = st ? riscv_isa_pkg::OPC_STORE : riscv_isa_pkg::OPC_LOAD;
      ctrl.memw      = st[0];
      ctrl.memr      = !st[0];
      ctrl.oprnd2sel = 1'b1;
      rs1  = next_rand() & ~64'h7;
      simm = 64'h40;
      #2;
      check_bit("mem rden", !st[0], mem_req.rden);
      check_bit("mem wren", st[0], mem_req.wren);
      check_value("mem addr", rs1 + 64'h40, mem_req.addr);
    end
    x = next_rand() & ~64'h7;
    drive_atomic(1'b0, x);
    check_bit("lr rden", 1'b1, mem_req.rden);
    check_value("lr addr", x, mem_req.addr);
    drive_atomic(1'b1, x);
    check_bit("sc ok wren", 1'b1, mem_req.wren);
    check_value("sc ok value", 64'd0, rddata_sc);
    drive_atomic(1'b1, x);
    check_bit("second sc wren", 1'b0, mem_req.wren);
    check_value("second sc value", 64'd1, rddata_sc);
    for (int t = 0; t < 2; t++) begin
      drive_atomic(1'b0, x);
      @(negedge clk);
      drive_idle();
      gtrap     = (t == 0);
      rtrap     = (t == 1);
      ctrl.memr = 1'b1;
      ctrl.memw = 1'b1;
      #2;
      check_bit("trap rden", 1'b0, mem_req.rden);
      check_bit("trap wren", 1'b0, mem_req.wren);
      drive_atomic(1'b1, x);
      check_bit("sc after trap wren", 1'b0, mem_req.wren);
      check_value("sc after trap value", 64'd1, rddata_sc);
    end
  endtask

  task automatic test_misalignment();
    logic mis;
    for (int ld = 0; ld < 2; ld++) begin
      for (int k = 0; k < 8; k++) begin
        for (int off = 0; off < 8; off++) begin
          @(negedge clk);
          drive_idle();
          ctrl.opcode    = ld ? riscv_isa_pkg::OPC_LOAD : riscv_isa_pkg::OPC_STORE;
          ctrl.memsize   = riscv_isa_pkg::memsize_e'(k);
          ctrl.oprnd2sel = 1'b1;
          rs1  = next_rand() & ~64'h7;
          simm = 64'(off);
          mis  = (off % (1 << (k % 4))) != 0;   // Offset not a multiple of the size
          #2;
          check_bit($sformatf("load trap size %0d off %0d", k, off), ld && mis,
                    traps.load_misaligned);
          check_bit($sformatf("store trap size %0d off %0d", k, off), !ld && mis,
                    traps.store_misaligned);
        end
      end
    end
    for (int kind = 0; kind < 3; kind++) begin   // Taken branch, untaken branch, jal
      for (int off = 0; off < 4; off++) begin
        @(negedge clk);
        drive_idle();
        ctrl.opcode    = (kind == 2) ? riscv_isa_pkg::OPC_JAL : riscv_isa_pkg::OPC_BRANCH;
        ctrl.bcond     = (kind == 2) ? riscv_isa_pkg::BC_JUMP : riscv_isa_pkg::BC_BEQ;
        ctrl.oprnd1sel = 1'b0;
        ctrl.oprnd2sel = 1'b1;
        pc   = next_rand() & ~64'h3;
        simm = (next_rand() & ~64'h3) | 64'(off);
        rs1  = next_rand();
        rs2  = (kind == 1) ? ~rs1 : rs1;
        #2;
        check_bit($sformatf("inst trap kind %0d off %0d", kind, off), kind != 1 && off != 0,
                  traps.inst_misaligned);
      end
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    errors    = 0;
    checks    = 0;
    lcg_state = 64'd45704;
    rs1       = '0;
    rs2       = '0;
    fwd       = '0;
    pc        = '0;
    simm      = '0;
    immext    = '0;
    drive_idle();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_alu_paths();
    test_forwarding();
    test_branches();
    test_muldiv();
    test_memory();
    test_misalignment();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/riscv_estage.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_estage (
  input  logic                            i_riscv_estage_clk,
  input  logic                            i_rst,
  input  riscv_estage_pkg::estage_ctrl_t  i_ctrl,
  input  logic [`RISCV_XLEN-1:0]          i_rs1data,
  input  logic [`RISCV_XLEN-1:0]          i_rs2data,
  input  riscv_estage_pkg::fwd_data_t     i_fwd,
  input  logic [`RISCV_XLEN-1:0]          i_pc,
  input  logic [`RISCV_XLEN-1:0]          i_simm,
  input  logic [`RISCV_XLEN-1:0]          i_immextended,   // CSR zimm
  input  logic                            i_gtrap,
  input  logic                            i_rtrap,
  output logic [`RISCV_XLEN-1:0]          o_result,
  output logic [`RISCV_XLEN-1:0]          o_store_data,
  output logic [`RISCV_XLEN-1:0]          o_csrwritedata,
  output logic                            o_branchtaken,
  output logic                            o_mul_en,        // Stall request to hazard unit
  output logic                            o_div_en,
  output logic                            o_icu_valid,
  output riscv_estage_pkg::mem_req_t      o_mem_req,
  output logic [`RISCV_XLEN-1:0]          o_rddata_sc,
  output riscv_estage_pkg::trap_flags_t   o_traps
);

  logic [`RISCV_XLEN-1:0] fwd_a;
  logic [`RISCV_XLEN-1:0] fwd_b;
  logic [`RISCV_XLEN-1:0] alu_a;
  logic [`RISCV_XLEN-1:0] alu_b;

  function automatic logic [`RISCV_XLEN-1:0] fwd_pick(
    input logic [1:0]                  sel,
    input logic [`RISCV_XLEN-1:0]      rs,
    input riscv_estage_pkg::fwd_data_t fwd
  );
    case (sel)
      2'd1:    return fwd.rdata_wb;
      2'd2:    return fwd.rddata_m;
      2'd3:    return fwd.imm_m;
      default: return rs;
    endcase
  endfunction

  assign fwd_a = fwd_pick(i_ctrl.fwda, i_rs1data, i_fwd);
  assign fwd_b = fwd_pick(i_ctrl.fwdb, i_rs2data, i_fwd);

  assign alu_a = i_ctrl.oprnd1sel ? fwd_a : i_pc;    // AUIPC and jumps use pc
  assign alu_b = i_ctrl.oprnd2sel ? i_simm : fwd_b;

  assign o_csrwritedata = i_ctrl.imm_reg ? i_immextended : fwd_a;
  assign o_store_data   = fwd_b;
  assign o_mul_en       = i_ctrl.muldiv_op[3] & ~i_ctrl.muldiv_op[2];
  assign o_div_en       = i_ctrl.muldiv_op[3] & i_ctrl.muldiv_op[2];

  riscv_icu u_icu (
    .i_riscv_icu_clk (i_riscv_estage_clk),
    .i_rst           (i_rst),
    .i_rs1data       (fwd_a),
    .i_rs2data       (fwd_b),
    .i_alua          (alu_a),
    .i_alub          (alu_b),
    .i_alu_op        (i_ctrl.alu_op),
    .i_bcond         (i_ctrl.bcond),
    .i_muldiv_op     (i_ctrl.muldiv_op),
    .i_funcsel       (i_ctrl.funcsel),
    .o_branch_taken  (o_branchtaken),
    .o_valid         (o_icu_valid),
    .o_result        (o_result)
  );

  riscv_lsu u_lsu (
    .i_riscv_lsu_clk (i_riscv_estage_clk),
    .i_rst           (i_rst),
    .i_rs1addr       (fwd_a),
    .i_alu_result    (o_result),
    .i_lr            (i_ctrl.lr),
    .i_sc            (i_ctrl.sc),
    .i_amo           (i_ctrl.amo),
    .i_memw          (i_ctrl.memw),
    .i_memr          (i_ctrl.memr),
    .i_gtrap         (i_gtrap),
    .i_rtrap         (i_rtrap),
    .o_mem_req       (o_mem_req),
    .o_sc_rdvalue    (o_rddata_sc)
  );

  riscv_misalignment_unit u_misalignment_unit (
    .i_opcode        (i_ctrl.opcode),
    .i_result        (o_result),        // Target or effective address
    .i_branch_taken  (o_branchtaken),
    .i_memsize       (i_ctrl.memsize),
    .o_traps         (o_traps)
  );

endmodule

// ==== rtl/riscv_misalignment_unit.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_misalignment_unit (
  input  riscv_isa_pkg::opcode_e         i_opcode,
  input  logic [`RISCV_XLEN-1:0]         i_result,
  input  logic                           i_branch_taken,
  input  riscv_isa_pkg::memsize_e        i_memsize,
  output riscv_estage_pkg::trap_flags_t  o_traps
);

  logic is_jump;
  logic data_misaligned;

  assign is_jump = (i_opcode == riscv_isa_pkg::OPC_BRANCH) |
                   (i_opcode == riscv_isa_pkg::OPC_JAL) |
                   (i_opcode == riscv_isa_pkg::OPC_JALR);

  // Size only, sign flag ignored
  always_comb begin
    case (i_memsize[1:0])
      2'b01:   data_misaligned = i_result[0];
      2'b10:   data_misaligned = |i_result[1:0];
      2'b11:   data_misaligned = |i_result[2:0];
      default: data_misaligned = 1'b0;   // Bytes are always aligned
    endcase
  end

  assign o_traps.inst_misaligned  = is_jump & i_branch_taken & (|i_result[1:0]);
  assign o_traps.load_misaligned  = (i_opcode == riscv_isa_pkg::OPC_LOAD) & data_misaligned;
  assign o_traps.store_misaligned = (i_opcode == riscv_isa_pkg::OPC_STORE) & data_misaligned;

endmodule

// ==== rtl/riscv_lsu.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_lsu (
  input  logic                        i_riscv_lsu_clk,
  input  logic                        i_rst,
  input  logic [`RISCV_XLEN-1:0]      i_rs1addr,
  input  logic [`RISCV_XLEN-1:0]      i_alu_result,
  input  logic                        i_lr,
  input  logic                        i_sc,
  input  logic                        i_amo,
  input  logic                        i_memw,
  input  logic                        i_memr,
  input  logic                        i_gtrap,
  input  logic                        i_rtrap,
  output riscv_estage_pkg::mem_req_t  o_mem_req,
  output logic [`RISCV_XLEN-1:0]      o_sc_rdvalue
);

  logic [`RISCV_XLEN-1:0] addr;
  logic [`RISCV_XLEN-1:0] resv_addr;
  logic                   resv_valid;
  logic                   trap;
  logic                   sc_ok;

  // Atomics address straight from rs1, no offset
  assign addr  = (i_lr | i_sc | i_amo) ? i_rs1addr : i_alu_result;
  assign trap  = i_gtrap | i_rtrap;
  assign sc_ok = resv_valid & (resv_addr == addr);

  assign o_mem_req.wren = i_memw & ~trap & (~i_sc | sc_ok);   // Failed SC writes nothing
  assign o_mem_req.rden = i_memr & ~trap;
  assign o_mem_req.addr = addr;

  assign o_sc_rdvalue = {{(`RISCV_XLEN-1){1'b0}}, ~sc_ok};   // 0 on success

  always_ff @(posedge i_riscv_lsu_clk) begin
    if (i_rst) begin
      resv_valid <= `RISCV_RESV_INIT;
    end else if (trap) begin
      resv_valid <= 1'b0;
    end else if (i_lr & i_memr) begin
      resv_valid <= 1'b1;
    end else if (i_sc & i_memw) begin
      resv_valid <= 1'b0;   // Any SC consumes the reservation
    end
  end

  always_ff @(posedge i_riscv_lsu_clk) begin
    if (i_lr & i_memr & ~trap) resv_addr <= addr;
  end

endmodule

// ==== rtl/riscv_icu.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_icu (
  input  logic                       i_riscv_icu_clk,
  input  logic                       i_rst,
  input  logic [`RISCV_XLEN-1:0]     i_rs1data,
  input  logic [`RISCV_XLEN-1:0]     i_rs2data,
  input  logic [`RISCV_XLEN-1:0]     i_alua,
  input  logic [`RISCV_XLEN-1:0]     i_alub,
  input  riscv_isa_pkg::alu_op_e     i_alu_op,
  input  riscv_isa_pkg::bcond_e      i_bcond,
  input  riscv_isa_pkg::muldiv_op_e  i_muldiv_op,
  input  riscv_isa_pkg::funcsel_e    i_funcsel,
  output logic                       o_branch_taken,
  output logic                       o_valid,
  output logic [`RISCV_XLEN-1:0]     o_result
);

  logic [`RISCV_XLEN-1:0] alu_result;
  logic [`RISCV_XLEN-1:0] md_result;
  logic                   md_done;

  riscv_alu u_alu (
    .i_a      (i_alua),
    .i_b      (i_alub),
    .i_rs1    (i_rs1data),
    .i_rs2    (i_rs2data),
    .i_op     (i_alu_op),
    .i_bcond  (i_bcond),
    .o_result (alu_result),
    .o_taken  (o_branch_taken)
  );

  riscv_muldiv u_muldiv (
    .i_riscv_muldiv_clk (i_riscv_icu_clk),
    .i_rst              (i_rst),
    .i_op               (i_muldiv_op),
    .i_a                (i_rs1data),   // Forwarded registers, not the ALU operands
    .i_b                (i_rs2data),
    .o_busy             (),            // Stall comes from the enables upstream
    .o_done             (md_done),
    .o_result           (md_result)
  );

  assign o_result = (i_funcsel == riscv_isa_pkg::FS_MULDIV) ? md_result : alu_result;
  assign o_valid  = (i_funcsel == riscv_isa_pkg::FS_MULDIV) ? md_done : 1'b1;

endmodule

// ==== rtl/riscv_muldiv.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_muldiv (
  input  logic                       i_riscv_muldiv_clk,
  input  logic                       i_rst,
  input  riscv_isa_pkg::muldiv_op_e  i_op,
  input  logic [`RISCV_XLEN-1:0]     i_a,
  input  logic [`RISCV_XLEN-1:0]     i_b,
  output logic                       o_busy,
  output logic                       o_done,
  output logic [`RISCV_XLEN-1:0]     o_result
);

  localparam int XLEN  = `RISCV_XLEN;
  localparam int CNT_W = $clog2(`RISCV_MULDIV_STEPS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE,
    ST_WAIT_RELEASE
  } state_e;

  state_e                     state;
  logic [CNT_W-1:0]           step_cnt;
  riscv_isa_pkg::muldiv_op_e  op_q;
  logic                       res_neg;    // Negate the magnitude result
  logic [XLEN-1:0]            hi;         // Product high half or partial remainder
  logic [XLEN-1:0]            lo;         // Multiplier out, quotient in
  logic [XLEN-1:0]            opb;        // Multiplicand or divisor magnitude

  logic                       a_signed;
  logic                       b_signed;
  logic                       a_neg;
  logic                       b_neg;
  logic                       start_neg;
  logic [XLEN-1:0]            a_mag;
  logic [XLEN-1:0]            b_mag;
  logic [XLEN:0]              mul_sum;
  logic [XLEN:0]              div_shift;
  logic [XLEN+1:0]            div_diff;
  logic [2*XLEN-1:0]          prod;

  always_comb begin
    a_signed = 1'b0;
    b_signed = 1'b0;
    case (i_op)
      riscv_isa_pkg::MD_MULH, riscv_isa_pkg::MD_DIV, riscv_isa_pkg::MD_REM: begin
        a_signed = 1'b1;
        b_signed = 1'b1;
      end
      riscv_isa_pkg::MD_MULHSU: a_signed = 1'b1;
      default: ;
    endcase
  end

  assign a_neg = a_signed & i_a[XLEN-1];
  assign b_neg = b_signed & i_b[XLEN-1];
  assign a_mag = a_neg ? -i_a : i_a;
  assign b_mag = b_neg ? -i_b : i_b;

  always_comb begin
    case (i_op)
      riscv_isa_pkg::MD_DIV: start_neg = (a_neg ^ b_neg) & (|i_b);   // x/0 stays all ones
      riscv_isa_pkg::MD_REM: start_neg = a_neg;                      // Sign of the dividend
      default:               start_neg = a_neg ^ b_neg;
    endcase
  end

  // One shift-add or one restoring step per cycle
  assign mul_sum   = {1'b0, hi} + (lo[0] ? {1'b0, opb} : '0);
  assign div_shift = {hi, lo[XLEN-1]};
  assign div_diff  = {1'b0, div_shift} - {2'b00, opb};

  always_ff @(posedge i_riscv_muldiv_clk) begin
    if (i_rst) begin
      state    <= ST_IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          step_cnt <= '0;
          if (i_op[3]) state <= ST_RUN;
        end
        ST_RUN: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == CNT_W'(`RISCV_MULDIV_STEPS - 1)) state <= ST_DONE;
        end
        ST_DONE:         state <= i_op[3] ? ST_WAIT_RELEASE : ST_IDLE;
        ST_WAIT_RELEASE: if (!i_op[3]) state <= ST_IDLE;   // Held request must drop first
        default:         state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_riscv_muldiv_clk) begin
    if (state == ST_IDLE && i_op[3]) begin
      op_q    <= i_op;
      res_neg <= start_neg;
      hi      <= '0;
      lo      <= a_mag;
      opb     <= b_mag;
    end else if (state == ST_RUN) begin
      if (op_q[2]) begin
        hi <= div_diff[XLEN+1] ? div_shift[XLEN-1:0] : div_diff[XLEN-1:0];   // Restore on borrow
        lo <= {lo[XLEN-2:0], ~div_diff[XLEN+1]};
      end else begin
        hi <= mul_sum[XLEN:1];
        lo <= {mul_sum[0], lo[XLEN-1:1]};
      end
    end
  end

  assign prod = res_neg ? -{hi, lo} : {hi, lo};

  always_comb begin
    case (op_q)
      riscv_isa_pkg::MD_MUL:  o_result = prod[XLEN-1:0];
      riscv_isa_pkg::MD_MULH, riscv_isa_pkg::MD_MULHSU, riscv_isa_pkg::MD_MULHU: begin
        o_result = prod[2*XLEN-1:XLEN];
      end
      riscv_isa_pkg::MD_DIV, riscv_isa_pkg::MD_DIVU: o_result = res_neg ? -lo : lo;
      default: o_result = res_neg ? -hi : hi;
    endcase
  end

  assign o_busy = (state == ST_RUN);
  assign o_done = (state == ST_DONE);   // Single-cycle pulse

endmodule

// ==== rtl/riscv_alu.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_alu (
  input  logic [`RISCV_XLEN-1:0]  i_a,
  input  logic [`RISCV_XLEN-1:0]  i_b,
  input  logic [`RISCV_XLEN-1:0]  i_rs1,
  input  logic [`RISCV_XLEN-1:0]  i_rs2,
  input  riscv_isa_pkg::alu_op_e  i_op,
  input  riscv_isa_pkg::bcond_e   i_bcond,
  output logic [`RISCV_XLEN-1:0]  o_result,
  output logic                    o_taken
);

  logic [5:0] shamt;
  logic       rs_eq;
  logic       rs_lt;
  logic       rs_ltu;

  assign shamt = i_b[5:0];   // RV64 shifts use six bits

  always_comb begin
    case (i_op)
      riscv_isa_pkg::ALU_ADD:    o_result = i_a + i_b;
      riscv_isa_pkg::ALU_SUB:    o_result = i_a - i_b;
      riscv_isa_pkg::ALU_SLL:    o_result = i_a << shamt;
      riscv_isa_pkg::ALU_SLT: begin
        o_result = {{(`RISCV_XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
      end
      riscv_isa_pkg::ALU_SLTU:   o_result = {{(`RISCV_XLEN-1){1'b0}}, i_a < i_b};
      riscv_isa_pkg::ALU_XOR:    o_result = i_a ^ i_b;
      riscv_isa_pkg::ALU_SRL:    o_result = i_a >> shamt;
      riscv_isa_pkg::ALU_SRA:    o_result = $signed(i_a) >>> shamt;
      riscv_isa_pkg::ALU_OR:     o_result = i_a | i_b;
      riscv_isa_pkg::ALU_AND:    o_result = i_a & i_b;
      riscv_isa_pkg::ALU_PASS_B: o_result = i_b;
      default:                   o_result = '0;
    endcase
  end

  // Branch comparator works on the register values, not the ALU operands
  assign rs_eq  = (i_rs1 == i_rs2);
  assign rs_lt  = ($signed(i_rs1) < $signed(i_rs2));
  assign rs_ltu = (i_rs1 < i_rs2);

  always_comb begin
    case (i_bcond)
      riscv_isa_pkg::BC_BEQ:  o_taken = rs_eq;
      riscv_isa_pkg::BC_BNE:  o_taken = !rs_eq;
      riscv_isa_pkg::BC_BLT:  o_taken = rs_lt;
      riscv_isa_pkg::BC_BGE:  o_taken = !rs_lt;
      riscv_isa_pkg::BC_BLTU: o_taken = rs_ltu;
      riscv_isa_pkg::BC_BGEU: o_taken = !rs_ltu;
      riscv_isa_pkg::BC_JUMP: o_taken = 1'b1;   // Unconditional
      default:                o_taken = 1'b0;
    endcase
  end

endmodule

// ==== rtl/riscv_estage_pkg.sv ====
`include "riscv_config.svh"

package riscv_estage_pkg;

  // Decoded control word for the execute stage
  typedef struct packed {
    logic [1:0]                 fwda;       // 0 rs, 1 wb, 2 mem result, 3 mem imm
    logic [1:0]                 fwdb;
    logic                       oprnd1sel;  // 0 selects pc
    logic                       oprnd2sel;  // 1 selects immediate
    riscv_isa_pkg::alu_op_e     alu_op;
    riscv_isa_pkg::bcond_e      bcond;
    riscv_isa_pkg::muldiv_op_e  muldiv_op;
    riscv_isa_pkg::funcsel_e    funcsel;
    riscv_isa_pkg::opcode_e     opcode;
    riscv_isa_pkg::memsize_e    memsize;
    logic                       memw;
    logic                       memr;
    logic                       lr;
    logic                       sc;
    logic                       amo;
    logic                       imm_reg;    // CSR data from the immediate
  } estage_ctrl_t;

  typedef struct packed {
    logic [`RISCV_XLEN-1:0] rdata_wb;   // Write-back result
    logic [`RISCV_XLEN-1:0] rddata_m;   // Memory-stage result
    logic [`RISCV_XLEN-1:0] imm_m;      // Memory-stage immediate
  } fwd_data_t;

  // Data-cache request
  typedef struct packed {
    logic                   wren;
    logic                   rden;
    logic [`RISCV_XLEN-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic inst_misaligned;
    logic load_misaligned;
    logic store_misaligned;
  } trap_flags_t;

endpackage

// ==== rtl/riscv_isa_pkg.sv ====
package riscv_isa_pkg;

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [5:0] {
    ALU_ADD    = 6'd0,
    ALU_SUB    = 6'd1,
    ALU_SLL    = 6'd2,
    ALU_SLT    = 6'd3,
    ALU_SLTU   = 6'd4,
    ALU_XOR    = 6'd5,
    ALU_SRL    = 6'd6,
    ALU_SRA    = 6'd7,
    ALU_OR     = 6'd8,
    ALU_AND    = 6'd9,
    ALU_PASS_B = 6'd10   // LUI result is the immediate
  } alu_op_e;

  typedef enum logic [3:0] {
    BC_NONE = 4'b0000,
    BC_BEQ  = 4'b1000,
    BC_BNE  = 4'b1001,
    BC_JUMP = 4'b1010,   // JAL and JALR
    BC_BLT  = 4'b1100,
    BC_BGE  = 4'b1101,
    BC_BLTU = 4'b1110,
    BC_BGEU = 4'b1111
  } bcond_e;

  // Bit 3 enables the unit, bit 2 picks the divider
  typedef enum logic [3:0] {
    MD_NONE   = 4'b0000,
    MD_MUL    = 4'b1000,
    MD_MULH   = 4'b1001,
    MD_MULHSU = 4'b1010,
    MD_MULHU  = 4'b1011,
    MD_DIV    = 4'b1100,
    MD_DIVU   = 4'b1101,
    MD_REM    = 4'b1110,
    MD_REMU   = 4'b1111
  } muldiv_op_e;

  typedef enum logic [1:0] {
    FS_ALU    = 2'b00,
    FS_MULDIV = 2'b01
  } funcsel_e;

  // Bit 2 marks unsigned, bits 1:0 give log2 of the byte count
  typedef enum logic [2:0] {
    MS_B  = 3'b000,
    MS_H  = 3'b001,
    MS_W  = 3'b010,
    MS_D  = 3'b011,
    MS_BU = 3'b100,
    MS_HU = 3'b101,
    MS_WU = 3'b110,
    MS_DU = 3'b111
  } memsize_e;

endpackage

// ==== include/riscv_config.svh ====
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// Data path width
`define RISCV_XLEN 64

// One multiply/divide iteration per operand bit
`define RISCV_MULDIV_STEPS 64

// Reservation valid flag out of reset
`define RISCV_RESV_INIT 1'b0

`endif
